// ==== common/aipPkg.sv ====
package aipPkg;

  // Bus and field widths
  localparam int dataWidth   = 32;
  localparam int codeWidth   = 5;
  localparam int statusWidth = 8;
  localparam int ptrWidth    = 16;  // Pointer field in the low data bits

  // Storage sizes
  localparam int memInDepth   = 4;
  localparam int memOutDepth  = 128;
  localparam int confRegCount = 4;

  localparam int memInAddrWidth  = $clog2(memInDepth);
  localparam int memOutAddrWidth = $clog2(memOutDepth);
  localparam int confAddrWidth   = $clog2(confRegCount);

  localparam logic [dataWidth-1:0] ipId = 32'h00001006;

  // Register codes
  localparam logic [codeWidth-1:0] codeMemInData  = 5'd0;
  localparam logic [codeWidth-1:0] codeMemInPtr   = 5'd1;
  localparam logic [codeWidth-1:0] codeMemOutData = 5'd2;
  localparam logic [codeWidth-1:0] codeMemOutPtr  = 5'd3;
  localparam logic [codeWidth-1:0] codeConfData   = 5'd4;
  localparam logic [codeWidth-1:0] codeConfPtr    = 5'd5;
  localparam logic [codeWidth-1:0] codeStart      = 5'd6;
  localparam logic [codeWidth-1:0] codeStatus     = 5'd30;
  localparam logic [codeWidth-1:0] codeId         = 5'd31;

  typedef logic [dataWidth-1:0] wordT;

endpackage

// ==== common/aipHostIf.sv ====
`timescale 1ns/1ps

interface aipHostIf;
  import aipPkg::*;

  logic                 writeStb;
  logic                 readStb;
  logic [codeWidth-1:0] code;
  wordT                 data;

  // Decode side sees the whole access
  modport ctrl (
    input writeStb,
    input readStb,
    input code,
    input data
  );

  modport sink (
    input data  // Enables come from decode
  );

endinterface

// ==== verilog/aipDualPortRam.sv ====
`timescale 1ns/1ps

module aipDualPortRam #(
  parameter int depth     = 4,
  parameter int addrWidth = $clog2(depth)
) (
  input  logic                 clk,
  input  logic                 wrEn_i,
  input  logic [addrWidth-1:0] wrAddr_i,
  input  aipPkg::wordT         wrData_i,
  input  logic [addrWidth-1:0] rdAddr_i,
  output aipPkg::wordT         rdData_o
);
  import aipPkg::*;

  wordT mem [depth];

  always_ff @(posedge clk) begin
    if (wrEn_i)
      mem[wrAddr_i] <= wrData_i;
  end

  assign rdData_o = mem[rdAddr_i];  // Async read

  // Writes stay inside the array
  assert property (@(posedge clk) wrEn_i |-> (int'(wrAddr_i) < depth));

endmodule

// ==== verilog/aipConfigRegs.sv ====
`timescale 1ns/1ps

module aipConfigRegs (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              en_i,
  aipHostIf.sink                                            host,
  input  logic                                              wrEn_i,
  input  logic [aipPkg::confAddrWidth-1:0]                  wrAddr_i,
  output logic [aipPkg::confRegCount*aipPkg::dataWidth-1:0] regs_o
);
  import aipPkg::*;

  wordT regs [confRegCount];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < confRegCount; i++)
        regs[i] <= '0;
    end else if (en_i && wrEn_i) begin
      regs[wrAddr_i] <= host.data;
    end
  end

  // Register 0 lands in the low word
  always_comb begin
    for (int i = 0; i < confRegCount; i++)
      regs_o[i*dataWidth +: dataWidth] = regs[i];
  end

endmodule

// ==== verilog/aipStatus.sv ====
`timescale 1ns/1ps

module aipStatus (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en_i,
  aipHostIf.sink                         host,
  input  logic                           wrEn_i,
  input  logic [aipPkg::statusWidth-1:0] coreStatus_i,
  input  logic                           coreDone_i,
  output aipPkg::wordT                   statusWord_o,
  output logic                           intReq_o
);
  import aipPkg::*;

  logic [statusWidth-1:0] flags;
  logic [statusWidth-1:0] mask;
  logic                   doneQ;
  logic                   doneEdge;
  logic [statusWidth-1:0] clrFlags;
  logic [statusWidth-1:0] setFlags;

  assign doneEdge = coreDone_i && !doneQ;
  assign clrFlags = wrEn_i ? host.data[15:8] : '0;
  assign setFlags = {{(statusWidth-1){1'b0}}, doneEdge};  // Only flag 0 in use

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      flags <= '0;
      mask  <= '0;
      doneQ <= 1'b0;
    end else if (en_i) begin
      doneQ <= coreDone_i;
      flags <= (flags & ~clrFlags) | setFlags;  // New edge wins over clear
      if (wrEn_i)
        mask <= host.data[23:16];
    end
  end

  assign statusWord_o = {8'h00, mask, flags, coreStatus_i};

  assign intReq_o = |(flags & mask);

  assert property (@(posedge clk) disable iff (!rst) !$isunknown(intReq_o));

endmodule

// ==== verilog/aipCtrl.sv ====
`timescale 1ns/1ps

module aipCtrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               en_i,
  aipHostIf.ctrl                             host,
  output logic                               memInWrEn_o,
  output logic [aipPkg::memInAddrWidth-1:0]  memInWrAddr_o,
  output logic [aipPkg::memOutAddrWidth-1:0] memOutRdAddr_o,
  input  aipPkg::wordT                       memOutRdData_i,
  output logic                               confWrEn_o,
  output logic [aipPkg::confAddrWidth-1:0]   confWrAddr_o,
  output logic                               statusWrEn_o,
  input  aipPkg::wordT                       statusWord_i,
  output logic                               startCore_o,
  output aipPkg::wordT                       dataOut_o
);
  import aipPkg::*;

  logic [ptrWidth-1:0] ptrField;
  logic [ptrWidth-1:0] memInPtr;
  logic [ptrWidth-1:0] memOutPtr;
  logic [ptrWidth-1:0] confPtr;
  logic                startQ;

  logic wrMemInData;
  logic wrMemInPtr;
  logic rdMemOutData;
  logic wrMemOutPtr;
  logic wrConfData;
  logic wrConfPtr;
  logic wrStart;

  assign ptrField = host.data[ptrWidth-1:0];

  // Code decode
  assign wrMemInData  = host.writeStb && (host.code == codeMemInData);
  assign wrMemInPtr   = host.writeStb && (host.code == codeMemInPtr);
  assign rdMemOutData = host.readStb && (host.code == codeMemOutData);
  assign wrMemOutPtr  = host.writeStb && (host.code == codeMemOutPtr);
  assign wrConfData   = host.writeStb && (host.code == codeConfData);
  assign wrConfPtr    = host.writeStb && (host.code == codeConfPtr);
  assign wrStart      = en_i && host.writeStb && (host.code == codeStart);

  assign memInWrEn_o  = en_i && wrMemInData;  // RAM has no enable of its own
  assign confWrEn_o   = wrConfData;
  assign statusWrEn_o = host.writeStb && (host.code == codeStatus);

  assign memInWrAddr_o  = memInPtr[memInAddrWidth-1:0];
  assign memOutRdAddr_o = memOutPtr[memOutAddrWidth-1:0];
  assign confWrAddr_o   = confPtr[confAddrWidth-1:0];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memInPtr  <= '0;
      memOutPtr <= '0;
      confPtr   <= '0;
    end else if (en_i) begin
      if (wrMemInPtr)
        memInPtr <= ptrField;
      else if (wrMemInData)
        memInPtr <= memInPtr + 1'b1;

      // Output pointer advances on reads
      if (wrMemOutPtr)
        memOutPtr <= ptrField;
      else if (rdMemOutData)
        memOutPtr <= memOutPtr + 1'b1;

      if (wrConfPtr) begin
        confPtr <= ptrField;
      end else if (wrConfData) begin
        if (confPtr >= ptrWidth'(confRegCount - 1))
          confPtr <= '0;  // Wrap at bank size
        else
          confPtr <= confPtr + 1'b1;
      end
    end
  end

  // Start pulse lasts one cycle and falls when en drops
  always_ff @(posedge clk or negedge rst) begin
    if (!rst)
      startQ <= 1'b0;
    else
      startQ <= wrStart;
  end

  assign startCore_o = startQ;

  // Readback select
  always_comb begin
    case (host.code)
      codeMemOutData: dataOut_o = memOutRdData_i;
      codeStatus:     dataOut_o = statusWord_i;
      codeId:         dataOut_o = ipId;
      default:        dataOut_o = '0;
    endcase
  end

  // Host never reads and writes in one cycle
  assert property (@(posedge clk) disable iff (!rst)
    !(host.readStb && host.writeStb));

endmodule

// ==== verilog/aipTop.sv ====
`timescale 1ns/1ps

module aipTop (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         en_i,
  // Host bus
  input  logic [aipPkg::codeWidth-1:0]                 code_i,
  input  logic                                         readStb_i,
  input  logic                                         writeStb_i,
  input  aipPkg::wordT                                 dataIn_i,
  output aipPkg::wordT                                 dataOut_o,
  output logic                                         intReq_o,
  // Core side
  input  logic [aipPkg::memInAddrWidth-1:0]            coreRdAddr_i,
  output aipPkg::wordT                                 coreRdData_o,
  input  logic                                         coreWrEn_i,
  input  logic [aipPkg::memOutAddrWidth-1:0]           coreWrAddr_i,
  input  aipPkg::wordT                                 coreWrData_i,
  output logic [aipPkg::confRegCount*aipPkg::dataWidth-1:0] confRegs_o,
  input  logic [aipPkg::statusWidth-1:0]               coreStatus_i,
  input  logic                                         coreDone_i,
  output logic                                         startCore_o
);
  import aipPkg::*;

  aipHostIf host ();

  logic                       memInWrEn;
  logic [memInAddrWidth-1:0]  memInWrAddr;
  logic [memOutAddrWidth-1:0] memOutRdAddr;
  wordT                       memOutRdData;
  logic                       confWrEn;
  logic [confAddrWidth-1:0]   confWrAddr;
  logic                       statusWrEn;
  wordT                       statusWord;

  assign host.writeStb = writeStb_i;
  assign host.readStb  = readStb_i;
  assign host.code     = code_i;
  assign host.data     = dataIn_i;

  aipCtrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .en_i           (en_i),
    .host           (host.ctrl),
    .memInWrEn_o    (memInWrEn),
    .memInWrAddr_o  (memInWrAddr),
    .memOutRdAddr_o (memOutRdAddr),
    .memOutRdData_i (memOutRdData),
    .confWrEn_o     (confWrEn),
    .confWrAddr_o   (confWrAddr),
    .statusWrEn_o   (statusWrEn),
    .statusWord_i   (statusWord),
    .startCore_o    (startCore_o),
    .dataOut_o      (dataOut_o)
  );

  // Host writes, core reads
  aipDualPortRam #(.depth(memInDepth)) memIn (
    .clk      (clk),
    .wrEn_i   (memInWrEn),
    .wrAddr_i (memInWrAddr),
    .wrData_i (dataIn_i),
    .rdAddr_i (coreRdAddr_i),
    .rdData_o (coreRdData_o)
  );

  // Core writes, host reads
  aipDualPortRam #(.depth(memOutDepth)) memOut (
    .clk      (clk),
    .wrEn_i   (coreWrEn_i),
    .wrAddr_i (coreWrAddr_i),
    .wrData_i (coreWrData_i),
    .rdAddr_i (memOutRdAddr),
    .rdData_o (memOutRdData)
  );

  aipConfigRegs u_confRegs (
    .clk      (clk),
    .rst      (rst),
    .en_i     (en_i),
    .host     (host.sink),
    .wrEn_i   (confWrEn),
    .wrAddr_i (confWrAddr),
    .regs_o   (confRegs_o)
  );

  aipStatus u_status (
    .clk          (clk),
    .rst          (rst),
    .en_i         (en_i),
    .host         (host.sink),
    .wrEn_i       (statusWrEn),
    .coreStatus_i (coreStatus_i),
    .coreDone_i   (coreDone_i),
    .statusWord_o (statusWord),
    .intReq_o     (intReq_o)
  );

endmodule

// ==== bench/aipTb.sv ====
`timescale 1ns/1ps

module aipTb;
  import aipPkg::*;

  localparam int waitLimit = 20;

  logic                              clk;
  logic                              rst;
  logic                              en;
  logic [codeWidth-1:0]              code;
  logic                              readStb;
  logic                              writeStb;
  wordT                              dataIn;
  wordT                              dataOut;
  logic                              intReq;
  logic [memInAddrWidth-1:0]         coreRdAddr;
  wordT                              coreRdData;
  logic                              coreWrEn;
  logic [memOutAddrWidth-1:0]        coreWrAddr;
  wordT                              coreWrData;
  logic [confRegCount*dataWidth-1:0] confRegs;
  logic [statusWidth-1:0]            coreStatus;
  logic                              coreDone;
  logic                              startCore;

  aipTop i_dut (
    .clk          (clk),
    .rst          (rst),
    .en_i         (en),
    .code_i       (code),
    .readStb_i    (readStb),
    .writeStb_i   (writeStb),
    .dataIn_i     (dataIn),
    .dataOut_o    (dataOut),
    .intReq_o     (intReq),
    .coreRdAddr_i (coreRdAddr),
    .coreRdData_o (coreRdData),
    .coreWrEn_i   (coreWrEn),
    .coreWrAddr_i (coreWrAddr),
    .coreWrData_i (coreWrData),
    .confRegs_o   (confRegs),
    .coreStatus_i (coreStatus),
    .coreDone_i   (coreDone),
    .startCore_o  (startCore)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input logic [8*32-1:0] name, input wordT expected,
                            input wordT actual);
    if (expected !== actual) begin
      $display("error %0s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout: %0s", what);
    $display("Test failed");
    $fatal(1, "Wait loop ran out of cycles");
  endtask

  task automatic hostWrite(input logic [codeWidth-1:0] c, input wordT d);
    @(posedge clk);
    writeStb <= 1'b1;
    code     <= c;
    dataIn   <= d;
    @(posedge clk);
    writeStb <= 1'b0;  // Sampled as high at this edge
  endtask

  task automatic hostRead(input logic [codeWidth-1:0] c, input wordT expected,
                          input logic [8*32-1:0] name);
    @(posedge clk);
    readStb <= 1'b1;
    code    <= c;
    @(negedge clk);
    checkValue(name, expected, dataOut);
    @(posedge clk);
    readStb <= 1'b0;
  endtask

  task automatic coreRead(input logic [31:0] addr, input wordT expected,
                          input logic [8*32-1:0] name);
    @(posedge clk);
    coreRdAddr <= addr[memInAddrWidth-1:0];
    @(negedge clk);
    checkValue(name, expected, coreRdData);
  endtask

  task automatic coreWrite(input logic [31:0] addr, input wordT d);
    @(posedge clk);
    coreWrEn   <= 1'b1;
    coreWrAddr <= addr[memOutAddrWidth-1:0];
    coreWrData <= d;
    @(posedge clk);
    coreWrEn <= 1'b0;
  endtask

  // Bit 8 drives done and the low byte the core status
  task automatic driveStatus(input wordT d);
    @(posedge clk);
    coreStatus <= d[statusWidth-1:0];
    coreDone   <= d[8];
  endtask

  task automatic checkConf(input int idx, input wordT expected, input logic [8*32-1:0] name);
    @(negedge clk);
    checkValue(name, expected, confRegs[idx*dataWidth +: dataWidth]);
  endtask

  // Issues the start write and measures the pulse width
  task automatic checkStart(input wordT expected, input logic [8*32-1:0] name);
    int cycles;
    int width;
    hostWrite(codeStart, '0);
    cycles = 0;
    @(negedge clk);
    while (!startCore) begin
      cycles++;
      if (cycles > waitLimit)
        reportTimeout("start pulse did not arrive");
      @(negedge clk);
    end
    width = 0;
    while (startCore) begin
      width++;
      if (width > waitLimit)
        reportTimeout("start pulse did not fall");
      @(negedge clk);
    end
    checkValue(name, expected, wordT'(width));
  endtask

  task automatic checkInterrupt(input wordT expected, input logic [8*32-1:0] name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (intReq !== expected[0]) begin
      cycles++;
      if (cycles > waitLimit)
        reportTimeout("interrupt request did not reach the expected level");
      @(negedge clk);
    end
    @(negedge clk);  // Level must hold
    checkValue(name, expected, wordT'(intReq));
  endtask

  initial begin
    int              fd;
    int              n;
    int unsigned     seedInit;
    int unsigned     gap;
    string           line;
    byte             op;
    logic [31:0]     arg;
    wordT            dat;
    wordT            expVal;
    logic [8*32-1:0] testName;

    clk        = 1'b0;
    rst        = 1'b0;
    en         = 1'b0;
    code       = '0;
    readStb    = 1'b0;
    writeStb   = 1'b0;
    dataIn     = '0;
    coreRdAddr = '0;
    coreWrEn   = 1'b0;
    coreWrAddr = '0;
    coreWrData = '0;
    coreStatus = '0;
    coreDone   = 1'b0;
    seedInit   = $urandom(32'h8de3);

    fd = $fopen("bench/aipGolden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden stimulus file");
      $display("Test failed");
      $fatal(1, "Missing stimulus file");
    end

    repeat (3) @(posedge clk);
    rst <= 1'b1;
    en  <= 1'b1;

    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %s", op, arg, dat, expVal, testName);
        if (n != 5) begin
          $display("Golden file line could not be parsed: %0s", line);
          $display("Test failed");
          $fatal(1, "Bad stimulus line");
        end
        gap = $urandom % 3;  // Idle cycles between operations
        repeat (gap) @(posedge clk);
        case (op)
          "W": hostWrite(arg[codeWidth-1:0], dat);
          "R": hostRead(arg[codeWidth-1:0], expVal, testName);
          "C": coreRead(arg, expVal, testName);
          "M": coreWrite(arg, dat);
          "S": driveStatus(dat);
          "F": checkConf(int'(arg), expVal, testName);
          "P": checkStart(expVal, testName);
          "I": checkInterrupt(expVal, testName);
          default: begin
            $display("Unknown operation letter in golden file: %c", op);
            $display("Test failed");
            $fatal(1, "Bad operation");
          end
        endcase
      end
    end
    $fclose(fd);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== bench/aipGolden.txt ====
# op code/addr data expected name   (all numbers hex, "-" for no name)
# W write, R read, C core read, M core write, S status (bit8 done), F conf, P start, I irq
R 1f 0 00001006 idRead
R 0a 0 00000000 unusedCode
W 01 0 0 -
W 00 11111111 0 -
W 00 22222222 0 -
W 00 33333333 0 -
W 00 44444444 0 -
C 0 0 11111111 memIn0
C 1 0 22222222 memIn1
C 2 0 33333333 memIn2
C 3 0 44444444 memIn3
M 00 a0000001 0 -
M 01 a0000002 0 -
M 02 a0000003 0 -
M 03 a0000004 0 -
M 04 a0000005 0 -
W 03 0 0 -
R 02 0 a0000001 memOut0
R 02 0 a0000002 memOut1
R 02 0 a0000003 memOut2
R 02 0 a0000004 memOut3
R 02 0 a0000005 memOut4
W 05 0 0 -
W 04 c0000001 0 -
W 04 c0000002 0 -
W 04 c0000003 0 -
W 04 c0000004 0 -
W 04 c0000005 0 -
F 0 0 c0000005 confWrap0
F 1 0 c0000002 confReg1
F 2 0 c0000003 confReg2
F 3 0 c0000004 confReg3
S 0 0000005a 0 -
P 0 0 1 startPulse
R 1e 0 0000005a statusRead
S 0 0000015a 0 -
S 0 0000005a 0 -
R 1e 0 0000015a flagSet
I 0 0 0 intMasked
W 1e 00010000 0 -
I 0 0 1 intRaised
W 1e 00010100 0 -
I 0 0 0 intCleared
R 1e 0 0001005a flagCleared

// ==== vlog.f ====
common/aipPkg.sv
common/aipHostIf.sv
verilog/aipDualPortRam.sv
verilog/aipConfigRegs.sv
verilog/aipStatus.sv
verilog/aipCtrl.sv
verilog/aipTop.sv
bench/aipTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module aipTb -o aipSim \
  || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/aipSim)"
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
